//--- src/pt_geom_pkg.sv
// Page table geometry
`default_nettype none

package pt_geom_pkg;

    // ====================
    // Table shape
    // ====================

    // One table page holds 512 entries
    localparam int PT_IDX_WIDTH = 9;

    // Levels of indirection, root is depth 0
    localparam int PT_DEPTH = 4;

    // Width of one page table entry
    localparam int PTE_WIDTH = 64;

    // ====================
    // Address widths
    // ====================

    localparam int PA_WIDTH = 42;
    localparam int PAGE_OFFSET_BITS = 12;

    // Line addresses count 64-byte lines
    localparam int LINE_OFFSET_BITS = 6;

    localparam int REQ_TAG_WIDTH = 8;

    // ====================
    // Types
    // ====================

    typedef logic [PT_IDX_WIDTH-1:0] pt_idx_t;
    typedef logic [$clog2(PT_DEPTH)-1:0] pt_depth_t;

    // Level indices of a walk, level 0 in the top element
    typedef pt_idx_t [PT_DEPTH-1:0] pt_idx_vec_t;

    // 4 KB virtual page index, same layout as pt_idx_vec_t
    typedef logic [PT_DEPTH*PT_IDX_WIDTH-1:0] va_page_t;

    // 4 KB physical page index
    typedef logic [PA_WIDTH-PAGE_OFFSET_BITS-1:0] pa_page_t;

    typedef logic [PA_WIDTH-LINE_OFFSET_BITS-1:0] line_addr_t;
    typedef logic [REQ_TAG_WIDTH-1:0] req_tag_t;

endpackage

`default_nettype wire

//--- src/pt_entry_pkg.sv
// Page table entry decoding
`default_nettype none

package pt_entry_pkg;

    import pt_geom_pkg::*;

    // Flag positions in the low bits of an entry
    localparam int PTE_TERMINAL_BIT = 0;

    // Software fills unused entries with all ones
    // so bit 3 stands in for the whole entry being invalid
    localparam int PTE_ERROR_BIT = 3;

    // Entry status, error has priority over terminal
    typedef struct packed
    {
        logic error;
        logic terminal;
    } pt_status_t;

    // Status flags of one entry word
    function automatic pt_status_t entry_status(input logic [PTE_WIDTH-1:0] w);
        pt_status_t s;
        s.error = w[PTE_ERROR_BIT];
        s.terminal = w[PTE_TERMINAL_BIT];
        return s;
    endfunction

    // Page pointed to by an entry
    // Next table page for a pointer, translated page for a terminal
    function automatic pa_page_t entry_page(input logic [PTE_WIDTH-1:0] w);
        return w[PA_WIDTH-1:PAGE_OFFSET_BITS];
    endfunction

endpackage

`default_nettype wire

//--- src/pt_mem_port.sv
// Page table memory port
`default_nettype none

module pt_mem_port
    import pt_geom_pkg::*;
    import pt_entry_pkg::*;
#(
    parameter int WORDS_PER_LINE = 8
)
(
    input  logic clk,
    input  logic reset,

    // From the walk controller
    input  logic issue,
    input  pa_page_t cur_page,
    input  pt_idx_t cur_idx,

    // Host memory read channel
    input  logic read_rdy,
    output logic read_en,
    output line_addr_t read_addr,
    input  logic read_data_en,
    input  logic [PTE_WIDTH*WORDS_PER_LINE-1:0] read_data,

    // Decoded entry back to the controller
    output logic entry_valid,
    output pt_status_t entry_status,
    output pa_page_t entry_page
);

    // An entry index splits into line within page and word within line
    localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);
    localparam int LINE_IDX_W = PT_IDX_WIDTH - WORD_IDX_W;

    logic [WORD_IDX_W-1:0] word_idx;
    logic [LINE_IDX_W-1:0] line_idx;
    logic [$bits(pa_page_t)+LINE_IDX_W-1:0] line_full;

    // Response pipeline
    logic data_en_q;
    logic data_en_qq;
    logic [WORDS_PER_LINE-1:0][PTE_WIDTH-1:0] line_q;
    logic [PTE_WIDTH-1:0] word_qq;

    assign {line_idx, word_idx} = cur_idx;

    // ====================
    // Read requests
    // ====================

    // Fire only when memory can take it, otherwise the controller holds
    assign read_en = issue && read_rdy;

    // Table page followed by the line holding the wanted entry
    assign line_full = {cur_page, line_idx};
    assign read_addr = line_addr_t'(line_full);

    // ====================
    // Read responses
    // ====================

    // Valid strobes, two stages
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_en_q <= 1'b0;
            data_en_qq <= 1'b0;
        end
        else
        begin
            data_en_q <= read_data_en;
            data_en_qq <= data_en_q;
        end
    end

    // Stage 1 holds the whole line
    // Stage 2 keeps only the entry named by cur_idx,
    // which is stable while the controller waits
    always_ff @(posedge clk)
    begin
        if (read_data_en)
        begin
            line_q <= read_data;
        end

        if (data_en_q)
        begin
            word_qq <= line_q[word_idx];
        end
    end

    // Decode straight off the stage 2 register
    assign entry_valid = data_en_qq;
    assign entry_status = pt_entry_pkg::entry_status(word_qq);
    assign entry_page = pt_entry_pkg::entry_page(word_qq);

endmodule

`default_nettype wire

//--- src/pt_walk_ctrl.sv
// Page table walk controller
`default_nettype none

module pt_walk_ctrl
    import pt_geom_pkg::*;
    import pt_entry_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Table root from software
    input  pa_page_t root_page,
    input  logic root_valid,

    // Translation requests
    input  logic req_en,
    input  va_page_t req_va,
    input  logic req_spec,
    input  req_tag_t req_tag,
    output logic req_rdy,

    // Memory port
    output logic issue,
    output pa_page_t cur_page,
    output pt_idx_t cur_idx,
    input  logic read_fire,
    input  logic entry_valid,
    input  pt_status_t entry_status,
    input  pa_page_t entry_page,

    // Translation responses
    output logic rsp_en,
    output pa_page_t rsp_pa,
    output req_tag_t rsp_tag,
    output logic rsp_big_page,
    output logic rsp_not_present
);

    // Deepest level, holds 4 KB pages
    localparam pt_depth_t LAST_DEPTH = pt_depth_t'(PT_DEPTH - 1);

    // A terminal entry one level up maps a 2 MB page
    localparam pt_depth_t BIG_PAGE_DEPTH = pt_depth_t'(PT_DEPTH - 2);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_READ_REQ,
        ST_WAIT,
        ST_EVAL,
        ST_DONE,
        ST_ERROR,
        ST_HALT
    } walk_state_t;

    walk_state_t state;

    // Root address is usable once seen valid in a register
    logic initialized;

    // Request held for the duration of the walk
    logic spec_q;
    req_tag_t tag_q;

    // Remaining level indices, current one in the top element
    pt_idx_vec_t idx_vec;
    pt_depth_t depth;

    // Entry captured from the memory port
    pt_status_t ent_status;
    pa_page_t next_page;

    logic accept;
    logic walk_fail;

    // One walk at a time
    assign req_rdy = initialized && (state == ST_IDLE);
    assign accept = req_en && req_rdy;

    assign issue = (state == ST_READ_REQ);
    assign cur_idx = idx_vec[PT_DEPTH-1];

    // Bad entry, or a pointer where only a page can be
    assign walk_fail = ent_status.error || (!ent_status.terminal && (depth == LAST_DEPTH));

    // ====================
    // State machine
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            initialized <= 1'b0;
            depth <= '0;
            rsp_en <= 1'b0;
        end
        else
        begin
            initialized <= root_valid;

            // Response strobe is a single cycle pulse
            rsp_en <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        state <= ST_READ_REQ;
                        depth <= '0;
                    end
                end

                // Held here under back-pressure
                ST_READ_REQ:
                begin
                    if (read_fire)
                    begin
                        state <= ST_WAIT;
                    end
                end

                ST_WAIT:
                begin
                    if (entry_valid)
                    begin
                        state <= ST_EVAL;
                    end
                end

                ST_EVAL:
                begin
                    if (walk_fail)
                    begin
                        state <= ST_ERROR;
                        rsp_en <= 1'b1;
                    end
                    else if (ent_status.terminal)
                    begin
                        state <= ST_DONE;
                        rsp_en <= 1'b1;
                    end
                    else
                    begin
                        // Pointer, descend one level
                        state <= ST_READ_REQ;
                        depth <= depth + pt_depth_t'(1);
                    end
                end

                ST_DONE:
                begin
                    state <= ST_IDLE;
                end

                // speculative failures recover, others stop the walker
                ST_ERROR:
                begin
                    state <= spec_q ? ST_IDLE : ST_HALT;
                end

                // Left only through reset
                ST_HALT:
                begin
                    state <= ST_HALT;
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Walk datapath
    // ====================

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            spec_q <= req_spec;
            tag_q <= req_tag;
            idx_vec <= pt_idx_vec_t'(req_va);
            cur_page <= root_page;
        end

        if ((state == ST_WAIT) && entry_valid)
        begin
            ent_status <= entry_status;
            next_page <= entry_page;
        end

        // Step to the next table page and the next level index
        if ((state == ST_EVAL) && !walk_fail && !ent_status.terminal)
        begin
            cur_page <= next_page;
            idx_vec <= {idx_vec[PT_DEPTH-2:0], pt_idx_t'(0)};
        end
    end

    // Response payload, valid with rsp_en
    always_ff @(posedge clk)
    begin
        if (state == ST_EVAL)
        begin
            rsp_pa <= next_page;
            rsp_tag <= tag_q;
            rsp_big_page <= !walk_fail && (depth == BIG_PAGE_DEPTH);
            rsp_not_present <= walk_fail;
        end
    end

endmodule

`default_nettype wire

//--- src/pt_walk_top.sv
// Page table walker top level
`default_nettype none

module pt_walk_top
    import pt_geom_pkg::*;
    import pt_entry_pkg::*;
#(
    parameter int WORDS_PER_LINE = 8
)
(
    input  logic clk,
    input  logic reset,

    // Table root
    input  pa_page_t root_page,
    input  logic root_valid,

    // Requests
    input  logic req_en,
    input  va_page_t req_va,
    input  logic req_spec,
    input  req_tag_t req_tag,
    output logic req_rdy,

    // Responses
    output logic rsp_en,
    output pa_page_t rsp_pa,
    output req_tag_t rsp_tag,
    output logic rsp_big_page,
    output logic rsp_not_present,

    // Host memory reads
    input  logic read_rdy,
    output logic read_en,
    output line_addr_t read_addr,
    input  logic read_data_en,
    input  logic [PTE_WIDTH*WORDS_PER_LINE-1:0] read_data
);

    // ====================
    // Controller to port
    // ====================

    logic issue;
    pa_page_t cur_page;
    pt_idx_t cur_idx;
    logic entry_valid;
    pt_status_t entry_status;
    pa_page_t entry_page;

    pt_walk_ctrl u_ctrl
    (
        .clk             (clk),
        .reset           (reset),
        .root_page       (root_page),
        .root_valid      (root_valid),
        .req_en          (req_en),
        .req_va          (req_va),
        .req_spec        (req_spec),
        .req_tag         (req_tag),
        .req_rdy         (req_rdy),
        .issue           (issue),
        .cur_page        (cur_page),
        .cur_idx         (cur_idx),
        // Accepted read, moves the controller on to waiting
        .read_fire       (read_en),
        .entry_valid     (entry_valid),
        .entry_status    (entry_status),
        .entry_page      (entry_page),
        .rsp_en          (rsp_en),
        .rsp_pa          (rsp_pa),
        .rsp_tag         (rsp_tag),
        .rsp_big_page    (rsp_big_page),
        .rsp_not_present (rsp_not_present)
    );

    pt_mem_port #(
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) u_mem_port
    (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .cur_page     (cur_page),
        .cur_idx      (cur_idx),
        .read_rdy     (read_rdy),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .entry_valid  (entry_valid),
        .entry_status (entry_status),
        .entry_page   (entry_page)
    );

endmodule

`default_nettype wire

//--- testbench/pt_walk_asserts.sv
// Walker protocol assertions
`default_nettype none

module pt_walk_asserts
(
    input  logic clk,
    input  logic reset,
    input  logic root_valid,
    input  logic req_rdy,
    input  logic rsp_en,
    input  logic read_en,
    input  logic read_rdy
);

    timeunit 1ns;
    timeprecision 100ps;

    // Failures seen, read back by the testbench at the end
    int fail_count = 0;

    // Set once root_valid has been high since reset
    logic root_seen;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            root_seen <= 1'b0;
        end
        else if (root_valid)
        begin
            root_seen <= 1'b1;
        end
    end

    // ====================
    // Protocol rules
    // ====================

    // No read while memory is busy
    read_needs_rdy: assert property (@(posedge clk) disable iff (reset)
        read_en |-> read_rdy)
    else
    begin
        fail_count++;
        $error("read_en high while read_rdy is low");
    end

    // Response strobe lasts one cycle
    rsp_single_cycle: assert property (@(posedge clk) disable iff (reset)
        rsp_en |=> !rsp_en)
    else
    begin
        fail_count++;
        $error("rsp_en high for two cycles in a row");
    end

    // No requests taken before a table root exists
    rdy_needs_root: assert property (@(posedge clk) disable iff (reset)
        req_rdy |-> root_seen)
    else
    begin
        fail_count++;
        $error("req_rdy high before root_valid was seen");
    end

endmodule

`default_nettype wire

//--- testbench/tb_pt_walk.sv
// Page table walker testbench
`default_nettype none

module tb_pt_walk
    import pt_geom_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS_PER_LINE = 8;
    localparam int CLK_PERIOD = 10;

    // Byte address to line address shift
    localparam int LINE_SHIFT = 3 + $clog2(WORDS_PER_LINE);
    localparam int VA_TOP = $bits(va_page_t) - 1;

    // Walks in the whole run set the watchdog time
    localparam int NUM_WALKS = 27;
    localparam int WAIT_LIMIT = 400;
    localparam int WATCHDOG_NS = (NUM_WALKS * 300 + 500) * CLK_PERIOD;

    localparam pa_page_t ROOT_PAGE = 30'h00080;
    localparam logic [63:0] ERROR_ENTRY = 64'h0000_0000_3fff_f009;

    logic clk;
    logic reset;
    logic root_valid;
    logic req_en;
    va_page_t req_va;
    logic req_spec;
    req_tag_t req_tag;
    logic req_rdy;
    logic rsp_en;
    pa_page_t rsp_pa;
    req_tag_t rsp_tag;
    logic rsp_big_page;
    logic rsp_not_present;
    logic read_rdy;
    logic read_en;
    line_addr_t read_addr;
    logic read_data_en;
    logic [64*WORDS_PER_LINE-1:0] read_data;

    // Host memory of 64-bit entries keyed by byte address
    logic [63:0] pt_mem [logic [63:0]];
    pa_page_t next_free = 30'h00100;

    // Line addresses the current walk must read in order
    line_addr_t exp_lines [$];
    int reads_seen = 0;
    logic bp_mode = 1'b0;
    int check_count = 0;
    int error_count = 0;

    pt_walk_top #(
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) dut
    (
        .clk             (clk),
        .reset           (reset),
        .root_page       (ROOT_PAGE),
        .root_valid      (root_valid),
        .req_en          (req_en),
        .req_va          (req_va),
        .req_spec        (req_spec),
        .req_tag         (req_tag),
        .req_rdy         (req_rdy),
        .rsp_en          (rsp_en),
        .rsp_pa          (rsp_pa),
        .rsp_tag         (rsp_tag),
        .rsp_big_page    (rsp_big_page),
        .rsp_not_present (rsp_not_present),
        .read_rdy        (read_rdy),
        .read_en         (read_en),
        .read_addr       (read_addr),
        .read_data_en    (read_data_en),
        .read_data       (read_data)
    );

    bind pt_walk_top pt_walk_asserts u_asserts
    (
        .clk        (clk),
        .reset      (reset),
        .root_valid (root_valid),
        .req_rdy    (req_rdy),
        .rsp_en     (rsp_en),
        .read_en    (read_en),
        .read_rdy   (read_rdy)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Memory model helpers
    // ====================

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok)
        else
        begin
            error_count++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    function automatic pt_idx_t level_idx(input va_page_t va, input int d);
        return va[VA_TOP - PT_IDX_WIDTH*d -: PT_IDX_WIDTH];
    endfunction

    function automatic logic [63:0] ent_addr(input pa_page_t page, input pt_idx_t idx);
        return {22'h0, page, idx, 3'b000};
    endfunction

    // Unwritten words read back with the error bit set
    function automatic logic [63:0] mem_read(input logic [63:0] addr);
        if (pt_mem.exists(addr))
        begin
            return pt_mem[addr];
        end
        return ({addr[31:0], addr[63:32]} ^ ~addr) | 64'h8;
    endfunction

    // Terminal entry with extra flag bits and a high bit that decode ignores
    function automatic logic [63:0] leaf_entry(input pa_page_t pa);
        return {1'b1, 21'h0, pa, 12'h061};
    endfunction

    // Pointer chain down to last_d with the given entry at the end
    function automatic void map_entry(input va_page_t va, input int last_d,
                                      input logic [63:0] leaf);
        pa_page_t page;
        logic [63:0] a;
        logic [63:0] ent;
        int d;
        page = ROOT_PAGE;
        for (d = 0; d < last_d; d++)
        begin
            a = ent_addr(page, level_idx(va, d));
            ent = mem_read(a);
            // Reuse an existing pointer or take a fresh table page
            if (!pt_mem.exists(a) || ent[0] || ent[3])
            begin
                ent = {22'h0, next_free, 12'h002};
                next_free = next_free + 30'd1;
                pt_mem[a] = ent;
            end
            page = ent[41:12];
        end
        pt_mem[ent_addr(page, level_idx(va, last_d))] = leaf;
    endfunction

    // Reference walk over the model memory that queues the lines it reads
    function automatic void model_walk(input va_page_t va, output pa_page_t pa,
                                       output logic big, output logic np);
        pa_page_t page;
        logic [63:0] a;
        logic [63:0] ent;
        int d;
        page = ROOT_PAGE;
        pa = '0;
        big = 1'b0;
        np = 1'b1;
        for (d = 0; d < PT_DEPTH; d++)
        begin
            a = ent_addr(page, level_idx(va, d));
            exp_lines.push_back(line_addr_t'(a >> LINE_SHIFT));
            ent = mem_read(a);
            if (ent[3] || (!ent[0] && d == PT_DEPTH - 1))
            begin
                return;
            end
            if (ent[0])
            begin
                pa = ent[41:12];
                big = (d == PT_DEPTH - 2);
                np = 1'b0;
                return;
            end
            page = ent[41:12];
        end
    endfunction

    // Memory may refuse reads at random in back-pressure mode
    initial
    begin : rdy_drive
        read_rdy = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            if (bp_mode)
            begin
                read_rdy = ($urandom_range(2, 0) != 0);
            end
            else
            begin
                read_rdy = 1'b1;
            end
        end
    end

    // Answers each read after 1 to 6 cycles with one read in flight
    initial
    begin : mem_model
        line_addr_t addr;
        line_addr_t want;
        logic [63:0] base;
        int lat;
        int w;
        read_data_en = 1'b0;
        read_data = '0;
        forever
        begin
            @(posedge clk);
            if (read_en)
            begin
                addr = read_addr;
                reads_seen++;
                if (exp_lines.size() == 0)
                begin
                    error_count++;
                    $display("Walker read line %h that the walk does not need", addr);
                end
                else
                begin
                    want = exp_lines.pop_front();
                    check(addr == want, $sformatf("read %0d at line %h, expected %h",
                                                  reads_seen, addr, want));
                end
                lat = $urandom_range(6, 1);
                repeat (lat - 1) @(posedge clk);
                #1;
                base = {28'h0, addr} << LINE_SHIFT;
                for (w = 0; w < WORDS_PER_LINE; w++)
                begin
                    read_data[64*w +: 64] = mem_read(base + 64'(8 * w));
                end
                read_data_en = 1'b1;
                @(posedge clk);
                #1;
                read_data_en = 1'b0;
            end
        end
    end

    // ====================
    // Walk driver
    // ====================

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // One request and its response against the reference walk
    task automatic run_walk(input va_page_t va, input logic spec, input int exp_reads);
        pa_page_t e_pa;
        logic e_big;
        logic e_np;
        req_tag_t tag;
        int n;
        tag = req_tag_t'($urandom);
        exp_lines.delete();
        model_walk(va, e_pa, e_big, e_np);
        reads_seen = 0;
        @(posedge clk);
        #1;
        req_va = va;
        req_spec = spec;
        req_tag = tag;
        req_en = 1'b1;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!req_rdy && n < WAIT_LIMIT);
        #1;
        req_en = 1'b0;
        if (n >= WAIT_LIMIT)
        begin
            error_count++;
            $display("Request for page %h not accepted within %0d cycles", va, WAIT_LIMIT);
            return;
        end
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!rsp_en && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT)
        begin
            error_count++;
            $display("No response for page %h within %0d cycles", va, WAIT_LIMIT);
            return;
        end
        check(rsp_tag == tag, $sformatf("rsp_tag %h, expected %h", rsp_tag, tag));
        check(rsp_not_present == e_np,
              $sformatf("rsp_not_present %b, expected %b", rsp_not_present, e_np));
        if (!e_np)
        begin
            check(rsp_pa == e_pa, $sformatf("rsp_pa %h, expected %h", rsp_pa, e_pa));
            check(rsp_big_page == e_big,
                  $sformatf("rsp_big_page %b, expected %b", rsp_big_page, e_big));
        end
        check(reads_seen == exp_reads,
              $sformatf("%0d reads for page %h, expected %0d", reads_seen, va, exp_reads));
    endtask

    // ====================
    // Directed tests
    // ====================

    // Low 3 bits of the last index pick a word in the middle of the line
    localparam va_page_t VA_4K = {9'h003, 9'h12a, 9'h0f5, 9'h0b4};

    task automatic test_no_root();
        @(posedge clk);
        #1;
        req_va = VA_4K;
        req_en = 1'b1;
        repeat (20)
        begin
            @(posedge clk);
            check(!req_rdy, "req_rdy high without a table root");
            check(!read_en, "read_en high without a table root");
        end
        #1;
        req_en = 1'b0;
        root_valid = 1'b1;
    endtask

    task automatic test_4k_page();
        map_entry(VA_4K, 3, leaf_entry(30'h2abcd));
        run_walk(VA_4K, 1'b1, 4);
    endtask

    task automatic test_2m_page();
        va_page_t va;
        va = {9'h003, 9'h12a, 9'h1c3, 9'h055};
        map_entry(va, 2, leaf_entry(30'h15400));
        run_walk(va, 1'b1, 3);
    endtask

    task automatic test_spec_fail();
        va_page_t va_err;
        va_page_t va_ptr;
        va_err = {9'h003, 9'h12b, 9'h010, 9'h020};
        va_ptr = {9'h003, 9'h12a, 9'h0f5, 9'h0b5};
        map_entry(va_err, 2, ERROR_ENTRY);
        // Pointer where only a 4 KB page may stand
        map_entry(va_ptr, 3, {22'h0, 30'h03333, 12'h002});
        run_walk(va_err, 1'b1, 3);
        run_walk(va_ptr, 1'b1, 4);
        run_walk(VA_4K, 1'b1, 4);
    endtask

    task automatic test_back_pressure();
        va_page_t va;
        logic big;
        bp_mode = 1'b1;
        repeat (20)
        begin
            va = va_page_t'({$urandom, $urandom});
            big = ($urandom_range(1, 0) == 1);
            map_entry(va, big ? 2 : 3, leaf_entry(pa_page_t'($urandom)));
            run_walk(va, 1'b1, big ? 3 : 4);
        end
        bp_mode = 1'b0;
    endtask

    // Walker stops for good until reset
    task automatic test_halt();
        va_page_t va;
        va = {9'h1ff, 9'h000, 9'h000, 9'h000};
        map_entry(va, 1, ERROR_ENTRY);
        run_walk(va, 1'b0, 2);
        @(posedge clk);
        #1;
        req_va = VA_4K;
        req_en = 1'b1;
        repeat (50)
        begin
            @(posedge clk);
            check(!req_rdy, "req_rdy high while halted");
        end
        #1;
        req_en = 1'b0;
        root_valid = 1'b0;
        apply_reset();
        root_valid = 1'b1;
        run_walk(VA_4K, 1'b1, 4);
    endtask

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin : main
        void'($urandom(32'h36f03be1));
        reset = 1'b1;
        root_valid = 1'b0;
        req_en = 1'b0;
        req_va = '0;
        req_spec = 1'b0;
        req_tag = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        test_no_root();
        test_4k_page();
        test_2m_page();
        test_spec_fail();
        test_back_pressure();
        test_halt();
        repeat (5) @(posedge clk);
        error_count += dut.u_asserts.fail_count;
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/pt_geom_pkg.sv
src/pt_entry_pkg.sv
src/pt_mem_port.sv
src/pt_walk_ctrl.sv
src/pt_walk_top.sv
testbench/pt_walk_asserts.sv
testbench/tb_pt_walk.sv

//--- Makefile
SIM       := verilator
TOP       := tb_pt_walk
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the log, not from the exit status
run: $(BIN)
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
